/* Makefile */
# Verilator build and run for the instruction cache testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTS PASSED

SOURCES = $(shell grep -v '^+' $(FILELIST))
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) icache_config.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the exit status
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache (
    input  wire logic                 clk,
    input  wire logic                 proc_reset,
    input  wire icache_pkg::proc_req_t proc_req,
    output icache_pkg::proc_rsp_t      proc_rsp,
    input  wire icache_pkg::mem_rsp_t  mem_rsp,
    output icache_pkg::mem_req_t       mem_req
);

    icache_pkg::addr_fields_t fields;

    logic hit;
    logic fill;
    logic from_mem;
    logic stall;

    logic [`ICACHE_WORD_BITS-1:0]       rdata;
    logic [`ICACHE_BLOCK_ADDR_BITS-1:0] block_addr;

    // memory is addressed by block, tag and index together
    assign block_addr = {fields.tag, fields.index};

    // address split and tag compare
    icache_lookup u_lookup (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (proc_req.addr),
        .fill       (fill),
        .fields     (fields),
        .hit        (hit)
    );

    // miss handling and memory handshake
    icache_refill u_refill (
        .clk        (clk),
        .proc_reset (proc_reset),
        .read       (proc_req.read),
        .hit        (hit),
        .block_addr (block_addr),
        .ready      (mem_rsp.ready),
        .mem_req    (mem_req),
        .stall      (stall),
        .fill       (fill),
        .from_mem   (from_mem)
    );

    // block store and word select
    icache_data_array u_data_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .fields     (fields),
        .hit        (hit),
        .fill       (fill),
        .from_mem   (from_mem),
        .mem_block  (mem_rsp.rdata),
        .rdata      (rdata)
    );

    assign proc_rsp.rdata = rdata;
    assign proc_rsp.stall = stall;

endmodule

`default_nettype wire

/* icache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_checker (
    input  wire logic                  clk,
    input  wire logic                  proc_reset,
    input  wire icache_pkg::proc_req_t proc_req,
    input  wire icache_pkg::proc_rsp_t proc_rsp,
    input  wire icache_pkg::mem_req_t  mem_req,
    input  wire icache_pkg::mem_rsp_t  mem_rsp,
    input  wire logic                  report,
    output int                         error_count
);

    // model of the valid bits and tags
    logic                        model_valid [`ICACHE_SETS];
    logic [`ICACHE_TAG_BITS-1:0] model_tag   [`ICACHE_SETS];

    // refill tracking
    logic                         in_refill  = 1'b0;
    logic                         ready_seen = 1'b0;
    logic [`ICACHE_ADDR_BITS-1:0] refill_addr;

    int checks        = 0;
    int hits          = 0;
    int misses        = 0;
    int data_errors   = 0;
    int miss_errors   = 0;
    int refill_errors = 0;
    int idle_errors   = 0;

    assign error_count = data_errors + miss_errors + refill_errors + idle_errors;

    // expected word is the word address, scrambled
    function automatic logic [31:0] expected_word(input logic [`ICACHE_ADDR_BITS-1:0] addr);
        return {2'b00, addr} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [`ICACHE_TAG_BITS-1:0] tag_of(
        input logic [`ICACHE_ADDR_BITS-1:0] addr
    );
        return addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    endfunction

    function automatic logic [`ICACHE_INDEX_BITS-1:0] index_of(
        input logic [`ICACHE_ADDR_BITS-1:0] addr
    );
        return addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    endfunction

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        logic [`ICACHE_ADDR_BITS-1:0] addr;
        logic                         predicted_miss;
        addr = proc_req.addr;
        if (proc_reset !== 1'b0) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                model_valid[s] = 1'b0;
            end
            in_refill  = 1'b0;
            ready_seen = 1'b0;
        end else if (in_refill) begin
            checks++;
            if (ready_seen) begin
                // cycle after ready, word comes from memory
                if (proc_rsp.stall !== 1'b0 || mem_req.read !== 1'b0) begin
                    refill_errors++;
                    $display("error at %0t: stall %b read %b in the cycle after ready",
                             $time, proc_rsp.stall, mem_req.read);
                end
                if (proc_rsp.rdata !== expected_word(refill_addr)) begin
                    data_errors++;
                    $display("error at %0t: fill data for %h is %h, expected %h", $time,
                             refill_addr, proc_rsp.rdata, expected_word(refill_addr));
                end
                model_valid[index_of(refill_addr)] = 1'b1;
                model_tag[index_of(refill_addr)]   = tag_of(refill_addr);
                in_refill  = 1'b0;
                ready_seen = 1'b0;
            end else begin
                if (proc_rsp.stall !== 1'b1 || mem_req.read !== 1'b1) begin
                    refill_errors++;
                    $display("error at %0t: stall %b read %b dropped before ready",
                             $time, proc_rsp.stall, mem_req.read);
                end
                if (mem_req.addr !== refill_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS]) begin
                    refill_errors++;
                    $display("error at %0t: block address %h moved during refill",
                             $time, mem_req.addr);
                end
                ready_seen = mem_rsp.ready;
            end
        end else if (proc_req.read === 1'b1) begin
            checks++;
            predicted_miss = !(model_valid[index_of(addr)] &&
                               model_tag[index_of(addr)] == tag_of(addr));
            if (proc_rsp.stall !== predicted_miss) begin
                miss_errors++;
                $display("error at %0t: addr %h stall %b, model predicts miss %b",
                         $time, addr, proc_rsp.stall, predicted_miss);
            end
            if (proc_rsp.stall === 1'b1) begin
                misses++;
                if (mem_req.read !== 1'b1 ||
                    mem_req.addr !== addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS]) begin
                    refill_errors++;
                    $display("error at %0t: miss on %h gives read %b block %h",
                             $time, addr, mem_req.read, mem_req.addr);
                end
                in_refill   = 1'b1;
                refill_addr = addr;
                ready_seen  = mem_rsp.ready;
            end else begin
                hits++;
                if (proc_rsp.rdata !== expected_word(addr)) begin
                    data_errors++;
                    $display("error at %0t: hit data for %h is %h, expected %h",
                             $time, addr, proc_rsp.rdata, expected_word(addr));
                end
                if (mem_req.read !== 1'b0) begin
                    miss_errors++;
                    $display("error at %0t: memory read on a hit at %h", $time, addr);
                end
            end
        end else begin
            checks++;
            if (proc_rsp.stall !== 1'b0 || mem_req.read !== 1'b0) begin
                idle_errors++;
                $display("error at %0t: idle cycle shows stall %b read %b",
                         $time, proc_rsp.stall, mem_req.read);
            end
        end
    end

    always @(posedge report) begin
        $display("checks %0d, hits %0d, misses %0d, data errors %0d, miss errors %0d, %s%0d, %s%0d",
                 checks, hits, misses, data_errors, miss_errors,
                 "refill errors ", refill_errors, "idle errors ", idle_errors);
    end

endmodule

`default_nettype wire

/* icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// direct-mapped geometry, one block of four words per set
`define ICACHE_SETS          8
`define ICACHE_INDEX_BITS    3
`define ICACHE_OFFSET_BITS   2

// processor side works on 32-bit word addresses
`define ICACHE_ADDR_BITS     30
`define ICACHE_WORD_BITS     32

// tag is everything above index and offset
`define ICACHE_TAG_BITS      25

// memory side moves whole blocks
`define ICACHE_BLOCK_BITS    128
`define ICACHE_BLOCK_ADDR_BITS 28

`endif

/* icache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_data_array (
    input  wire logic                          clk,
    input  wire logic                          proc_reset,
    input  wire icache_pkg::addr_fields_t      fields,
    input  wire logic                          hit,
    input  wire logic                          fill,
    input  wire logic                          from_mem,
    input  wire logic [`ICACHE_BLOCK_BITS-1:0] mem_block,
    output logic [`ICACHE_WORD_BITS-1:0]       rdata
);

    // one block per set
    logic [`ICACHE_BLOCK_BITS-1:0] store [`ICACHE_SETS];

    // rdata holds the last word returned between accesses
    logic [`ICACHE_WORD_BITS-1:0] rdata_q;

    logic [`ICACHE_BLOCK_BITS-1:0] stored_block;

    // word 0 sits in the low bits of the block
    function automatic logic [`ICACHE_WORD_BITS-1:0] word_of(
        input logic [`ICACHE_BLOCK_BITS-1:0]  block,
        input logic [`ICACHE_OFFSET_BITS-1:0] offset
    );
        logic [`ICACHE_WORD_BITS-1:0] word;
        word = block[offset * `ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];
        return word;
    endfunction

    assign stored_block = store[fields.index];

    always_ff @(posedge clk) begin
        if (fill) begin
            store[fields.index] <= mem_block;
        end
    end

    // memory data wins in the fill cycle because the store is not written yet
    always_comb begin
        rdata = rdata_q;
        if (from_mem) begin
            rdata = word_of(mem_block, fields.offset);
        end else if (hit) begin
            rdata = word_of(stored_block, fields.offset);
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rdata;
        end
    end

endmodule

`default_nettype wire

/* icache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_lookup (
    input  wire logic                         clk,
    input  wire logic                         proc_reset,
    input  wire logic [`ICACHE_ADDR_BITS-1:0] addr,
    input  wire logic                         fill,
    output icache_pkg::addr_fields_t          fields,
    output logic                              hit
);

    // one valid bit and one tag per set
    logic [`ICACHE_SETS-1:0]     valid;
    logic [`ICACHE_TAG_BITS-1:0] tags [`ICACHE_SETS];

    // stored tag of the addressed set
    logic [`ICACHE_TAG_BITS-1:0] stored_tag;
    logic                        tag_match;

    // address layout matches the struct bit for bit
    assign fields = icache_pkg::addr_fields_t'(addr);

    assign stored_tag = tags[fields.index];
    assign tag_match  = (stored_tag == fields.tag);

    // combinational lookup so a hit never stalls
    assign hit = valid[fields.index] & tag_match;

    // valid bits cleared by reset and set by fill
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid <= '0;
        end else if (fill) begin
            valid[fields.index] <= 1'b1;
        end
    end

    // tag store is written alongside the block store
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fields.index] <= fields.tag;
        end
    end

    // the refill controller only fills after a miss on the held address,
    // so the set being filled can never already hold this tag
    a_no_fill_on_hit: assert property (
        @(posedge clk) disable iff (proc_reset)
        fill |-> !hit
    ) else $error("icache_lookup: fill while address already hits");

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    `include "icache_config.svh"

    // refill controller states
    typedef enum logic {
        IDLE     = 1'b0,
        ALLOCATE = 1'b1
    } cache_state_e;

    // word address split, msb to lsb
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic [`ICACHE_INDEX_BITS-1:0]  index;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    // processor request
    typedef struct packed {
        logic                         read;
        logic [`ICACHE_ADDR_BITS-1:0] addr;
    } proc_req_t;

    // processor response
    typedef struct packed {
        logic [`ICACHE_WORD_BITS-1:0] rdata;
        logic                         stall;
    } proc_rsp_t;

    // block read request to memory
    typedef struct packed {
        logic                               read;
        logic [`ICACHE_BLOCK_ADDR_BITS-1:0] addr;
    } mem_req_t;

    // memory answer, data stays valid after the ready strobe
    typedef struct packed {
        logic [`ICACHE_BLOCK_BITS-1:0] rdata;
        logic                          ready;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* icache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_refill (
    input  wire logic                               clk,
    input  wire logic                               proc_reset,
    input  wire logic                               read,
    input  wire logic                               hit,
    input  wire logic [`ICACHE_BLOCK_ADDR_BITS-1:0] block_addr,
    input  wire logic                               ready,
    output icache_pkg::mem_req_t                    mem_req,
    output logic                                    stall,
    output logic                                    fill,
    output logic                                    from_mem
);

    icache_pkg::cache_state_e state;
    icache_pkg::cache_state_e state_next;

    // ready is taken one cycle late so fill lands in the cycle after the strobe
    logic ready_buf;

    // block address held for the whole allocate phase
    logic [`ICACHE_BLOCK_ADDR_BITS-1:0] addr_q;

    logic miss;

    assign miss = read & ~hit;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state     <= icache_pkg::IDLE;
            ready_buf <= 1'b0;
        end else begin
            state     <= state_next;
            ready_buf <= ready;
        end
    end

    // capture the block address when the miss is first seen
    always_ff @(posedge clk) begin
        if (state == icache_pkg::IDLE && miss) begin
            addr_q <= block_addr;
        end
    end

    always_comb begin
        state_next   = state;
        mem_req.read = 1'b0;
        mem_req.addr = addr_q;
        stall        = 1'b0;
        fill         = 1'b0;
        from_mem     = 1'b0;

        case (state)
            icache_pkg::IDLE: begin
                // miss stalls in the request cycle itself
                if (miss) begin
                    state_next   = icache_pkg::ALLOCATE;
                    mem_req.read = 1'b1;
                    mem_req.addr = block_addr;
                    stall        = 1'b1;
                end
            end
            icache_pkg::ALLOCATE: begin
                if (ready_buf) begin
                    // word comes straight from memory and the line is written at this edge
                    state_next = icache_pkg::IDLE;
                    fill       = 1'b1;
                    from_mem   = 1'b1;
                end else begin
                    mem_req.read = 1'b1;
                    stall        = 1'b1;
                end
            end
            default: begin
                state_next = icache_pkg::IDLE;
            end
        endcase
    end

    // processor keeps the missed address until the refill ends
    a_addr_held: assert property (
        @(posedge clk) disable iff (proc_reset)
        (state == icache_pkg::ALLOCATE) |-> (block_addr == addr_q)
    ) else $error("icache_refill: address changed during refill");

    // ready is a single-cycle strobe inside a pending refill
    a_ready_strobe: assert property (
        @(posedge clk) disable iff (proc_reset)
        ready |-> (state == icache_pkg::ALLOCATE && !ready_buf)
    ) else $error("icache_refill: ready outside a pending refill");

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
icache_pkg.sv
icache_lookup.sv
icache_refill.sv
icache_data_array.sv
icache.sv
icache_checker.sv
tb_icache.sv

/* tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module tb_icache;

    localparam int NUM_REQUESTS = 2000;
    // worst miss covers request, up to six cycles to ready, fill and one spare cycle
    localparam int MISS_COST      = 9;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * MISS_COST + 200;
    localparam int DRIVE_DELAY    = 2;

    // two tags differing only in the top bit, so every set sees conflict evictions
    localparam logic [`ICACHE_TAG_BITS-1:0] TAG_A = 25'h0a5c3e1;
    localparam logic [`ICACHE_TAG_BITS-1:0] TAG_B = 25'h1a5c3e1;

    logic clk        = 1'b0;
    logic proc_reset = 1'b1;

    icache_pkg::proc_req_t proc_req;
    icache_pkg::proc_rsp_t proc_rsp;
    icache_pkg::mem_req_t  mem_req;
    icache_pkg::mem_rsp_t  mem_rsp;

    logic                         report;
    int                           error_count;
    int                           cycle_count = 0;
    logic [31:0]                  rng_state;
    logic [`ICACHE_ADDR_BITS-1:0] last_addr;

    icache u_icache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_rsp    (mem_rsp),
        .mem_req    (mem_req)
    );

    icache_checker u_checker (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .proc_req    (proc_req),
        .proc_rsp    (proc_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .report      (report),
        .error_count (error_count)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    // word i of a block is block address * 4 + i xored with a constant
    function automatic logic [`ICACHE_BLOCK_BITS-1:0] block_pattern(
        input logic [`ICACHE_BLOCK_ADDR_BITS-1:0] blk
    );
        logic [`ICACHE_BLOCK_BITS-1:0] block;
        logic [31:0]                   word;
        block = '0;
        for (int i = 0; i < 4; i++) begin
            word = ((32'(blk) << 2) + 32'(i)) ^ 32'h5a5a0000;
            block[i*32 +: 32] = word;
        end
        return block;
    endfunction

    // memory model with random latency that keeps data after the strobe
    initial begin
        logic [`ICACHE_BLOCK_ADDR_BITS-1:0] blk;
        logic [31:0]                        r;
        int                                 delay;
        mem_rsp = '0;
        forever begin
            @(negedge clk);
            if (mem_req.read === 1'b1 && proc_reset === 1'b0) begin
                blk = mem_req.addr;
                next_random(r);
                delay = 1 + int'(r % 6);
                repeat (delay) @(posedge clk);
                #DRIVE_DELAY;
                mem_rsp.rdata = block_pattern(blk);
                mem_rsp.ready = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                mem_rsp.ready = 1'b0;
            end
        end
    end

    // one request held until stall is low
    task automatic issue_request();
        logic [31:0]                  r;
        logic [`ICACHE_ADDR_BITS-1:0] addr;
        next_random(r);
        if (r[4:2] == 3'd0) begin
            addr = last_addr;
        end else begin
            addr = {(r[5] ? TAG_A : TAG_B), r[10:6]};
        end
        proc_req.read = (r[1:0] != 2'b00);
        proc_req.addr = addr;
        last_addr     = addr;
        @(negedge clk);
        while (proc_rsp.stall !== 1'b0) @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_reset();
        proc_req.read = 1'b0;
        proc_reset    = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        proc_reset = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        proc_reset = 1'b1;
        proc_req   = '0;
        report     = 1'b0;
        rng_state  = 32'ha887;
        last_addr  = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        proc_reset = 1'b0;
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            if (n == NUM_REQUESTS / 2) begin
                apply_reset();
            end
            issue_request();
        end
        proc_req.read = 1'b0;
        repeat (4) @(posedge clk);
        report = 1'b1;
        #1;
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
